// ==== flist.f ====
verilog/arm_isa_pkg.sv
verilog/control_pkg.sv
verilog/instruction_decoder.sv
verilog/pipeline_sequencer.sv
verilog/control_unit.sv
verification/control_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the control unit testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=control_unit_sim
LOG_FILE=sim.log

verilator --binary --timing -f flist.f --top-module control_unit_tb \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "result: build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"

if grep -q "Simulation failed" "$LOG_FILE"; then
    echo "result: FAIL"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "result: simulator exited with status $run_status"
    exit 1
fi

echo "result: PASS"
exit 0

// ==== verification/control_unit_tb.sv ====
`timescale 1ns/1ps

module control_unit_tb
    import arm_isa_pkg::*;
    import control_pkg::*;
();

    localparam int RESET_CYCLES = 5;
    localparam int NUM_ENTRIES  = 10;
    localparam int MAX_CYCLES   = 8 * NUM_ENTRIES + 50;

    // one instruction with the controls it should produce
    typedef struct packed {
        word_t       instr;
        cpsr_flags_t flags;
        alu_op_t     alu_op;
        reg_idx_t    write_sel;
        logic        reg_write_en;
        logic        cpsr_write_en;
        logic        imm_en;
        word_t       immediate;
        reg_idx_t    read_a_sel;
        reg_idx_t    read_b_sel;
        shift_op_t   shift_op;
        shift_amt_t  shift_amount;
        logic        mem_write;    // cycles with mem_write_en high
        logic        mem_read;     // cycles with mem_data_en high
        logic [3:0]  cycles;       // fetch to fetch
    } test_entry_t;

    logic           clk;
    logic           reset;
    word_t          instruction;
    cpsr_flags_t    flags;
    datapath_ctrl_t ctrl;
    logic           control_reset;
    int             cycle_count = 0;

    // instr, flags, alu_op, write_sel, reg_write_en, cpsr_write_en, imm_en, immediate
    // read_a_sel, read_b_sel, shift_op, shift_amount, mem_write, mem_read, cycles
    test_entry_t tests [NUM_ENTRIES] = '{
        // add r1, r2, #0xff ror 8
        '{32'hE282_14FF, 4'b0000, ALU_ADD, 4'd1, 1'b1, 1'b0, 1'b1, 32'hFF00_0000,
          4'd2, 4'd0, SHIFT_LSL, 5'd0, 1'b0, 1'b0, 4'd3},
        // subs r3, r4, #0x3f0
        '{32'hE254_3E3F, 4'b0000, ALU_SUB, 4'd3, 1'b1, 1'b1, 1'b1, 32'h0000_03F0,
          4'd4, 4'd0, SHIFT_LSL, 5'd0, 1'b0, 1'b0, 4'd3},
        // movs r5, r6, asr #5
        '{32'hE1B0_52C6, 4'b0000, ALU_MOV, 4'd5, 1'b1, 1'b1, 1'b0, 32'h0000_0000,
          4'd0, 4'd6, SHIFT_ASR, 5'd5, 1'b0, 1'b0, 4'd3},
        // mov r7, r8, rrx
        '{32'hE1A0_7068, 4'b0000, ALU_MOV, 4'd7, 1'b1, 1'b0, 1'b0, 32'h0000_0000,
          4'd0, 4'd8, SHIFT_RRX, 5'd0, 1'b0, 1'b0, 4'd3},
        // cmp r9, #1
        '{32'hE359_0001, 4'b0000, ALU_CMP, 4'd0, 1'b0, 1'b1, 1'b1, 32'h0000_0001,
          4'd9, 4'd0, SHIFT_LSL, 5'd0, 1'b0, 1'b0, 4'd3},
        // addeq r10, r11, r12 with z clear
        '{32'h008B_A00C, 4'b0000, ALU_MOV, 4'd0, 1'b0, 1'b0, 1'b0, 32'h0000_0000,
          4'd0, 4'd0, SHIFT_LSL, 5'd0, 1'b0, 1'b0, 4'd3},
        // addeq r10, r11, r12 with z set
        '{32'h008B_A00C, 4'b0100, ALU_ADD, 4'd10, 1'b1, 1'b0, 1'b0, 32'h0000_0000,
          4'd11, 4'd12, SHIFT_LSL, 5'd0, 1'b0, 1'b0, 4'd3},
        // str r1, [r2, #0x10]
        '{32'hE582_1010, 4'b0000, ALU_ADD, 4'd1, 1'b0, 1'b0, 1'b1, 32'h0000_0010,
          4'd2, 4'd1, SHIFT_LSL, 5'd0, 1'b1, 1'b0, 4'd4},
        // ldr r3, [r4, #-0x24]
        '{32'hE514_3024, 4'b0000, ALU_SUB, 4'd3, 1'b0, 1'b0, 1'b1, 32'h0000_0024,
          4'd4, 4'd3, SHIFT_LSL, 5'd0, 1'b0, 1'b1, 4'd5},
        // ldrne r5, [r6, #4] with z set
        '{32'h1596_5004, 4'b0100, ALU_MOV, 4'd0, 1'b0, 1'b0, 1'b0, 32'h0000_0000,
          4'd0, 4'd0, SHIFT_LSL, 5'd0, 1'b0, 1'b0, 4'd3}
    };

    control_unit control_unit_i (
        .clk           (clk),
        .reset         (reset),
        .instruction   (instruction),
        .flags         (flags),
        .ctrl          (ctrl),
        .control_reset (control_reset)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #4 clk = ~clk;
        end
    end

    // run limit
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                                 input string what);
        if (actual !== expected)
        begin
            $display("error at %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1, "mismatch");
        end
    endtask

    // pc increment marks the end of an instruction
    function automatic logic end_marker(input datapath_ctrl_t c);
        return c.pc_write_en && c.update_address && (c.addr_sel == ADDR_INC);
    endfunction

    task automatic check_reset_outputs();
        compare_value(32'(control_reset), 32'd1, "control_reset in reset");
        compare_value(32'(ctrl.mem_write_en), 32'd0, "mem_write_en in reset");
        compare_value(32'(ctrl.reg_write_en), 32'd0, "reg_write_en in reset");
        compare_value(32'(ctrl.pc_write_en), 32'd0, "pc_write_en in reset");
        compare_value(32'(ctrl.cpsr_write_en), 32'd0, "cpsr_write_en in reset");
        compare_value(32'(ctrl.mem_data_en), 32'd0, "mem_data_en in reset");
        compare_value(32'(ctrl.imm_en), 32'd0, "imm_en in reset");
    endtask

    // called on the falling edge where the marker is visible (fetch)
    task automatic run_entry(input int idx);
        test_entry_t e;
        int          cycles;
        int          write_cycles;
        int          load_cycles;
        e            = tests[idx];
        write_cycles = 0;
        load_cycles  = 0;
        instruction  = e.instr;
        flags        = e.flags;
        @(negedge clk);  // decode
        compare_value(32'(ctrl.pc_write_en), 32'd0, "marker after one cycle");
        @(negedge clk);  // decoded controls registered
        cycles = 2;
        compare_value(32'(ctrl.alu_op), 32'(e.alu_op), "alu_op");
        compare_value(32'(ctrl.write_sel), 32'(e.write_sel), "write_sel");
        compare_value(32'(ctrl.reg_write_en), 32'(e.reg_write_en), "reg_write_en");
        compare_value(32'(ctrl.cpsr_write_en), 32'(e.cpsr_write_en), "cpsr_write_en");
        compare_value(32'(ctrl.imm_en), 32'(e.imm_en), "imm_en");
        compare_value(ctrl.immediate, e.immediate, "immediate");
        compare_value(32'(ctrl.read_a_sel), 32'(e.read_a_sel), "read_a_sel");
        compare_value(32'(ctrl.read_b_sel), 32'(e.read_b_sel), "read_b_sel");
        compare_value(32'(ctrl.shift_op), 32'(e.shift_op), "shift_op");
        compare_value(32'(ctrl.shift_amount), 32'(e.shift_amount), "shift_amount");
        while (!end_marker(ctrl))
        begin
            // register file, immediate or read data on the b bus
            compare_value(32'(ctrl.read_b_en) + 32'(ctrl.imm_en) + 32'(ctrl.mem_data_en),
                          32'd1, "b bus driver count");
            if (ctrl.mem_write_en)
            begin
                write_cycles = write_cycles + 1;
                compare_value(32'(ctrl.addr_sel), 32'(ADDR_ALU), "store address select");
            end
            if (ctrl.mem_data_en)  // load data cycle
            begin
                load_cycles = load_cycles + 1;
                compare_value(32'(ctrl.reg_write_en), 32'd1, "load reg_write_en");
                compare_value(32'(ctrl.write_sel), 32'(e.write_sel), "load write_sel");
                compare_value(32'(ctrl.alu_op), 32'(ALU_MOV), "load alu_op");
            end
            @(negedge clk);
            cycles = cycles + 1;
        end
        compare_value(cycles, 32'(e.cycles), "cycle count");
        compare_value(write_cycles, 32'(e.mem_write), "mem_write_en cycles");
        compare_value(load_cycles, 32'(e.mem_read), "mem_data_en cycles");
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial
    begin
        int cycles;
        reset       = 1'b1;
        instruction = NOP_INSTRUCTION;
        flags       = 4'b0000;
        repeat (RESET_CYCLES)
        begin
            @(negedge clk);
            check_reset_outputs();
        end
        reset  = 1'b0;
        cycles = 0;
        while (!end_marker(ctrl))
        begin
            @(negedge clk);
            cycles = cycles + 1;
        end
        compare_value(cycles, 32'd2, "cycles from reset release to first marker");
        compare_value(32'(control_reset), 32'd0, "control_reset after reset");

        for (int i = 0; i < NUM_ENTRIES; i++)
        begin
            run_entry(i);
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== verilog/control_unit.sv ====
`timescale 1ns/1ps

module control_unit
    import arm_isa_pkg::*;
    import control_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  word_t          instruction,
    input  cpsr_flags_t    flags,
    output datapath_ctrl_t ctrl,
    output logic           control_reset
);

    word_t         fetched_instr;
    decoded_ctrl_t decoded;
    logic          fetch_strobe;

    // fetch register
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            fetched_instr <= NOP_INSTRUCTION;
        end
        else if (fetch_strobe)
        begin
            fetched_instr <= instruction;  // word valid during FETCH
        end
    end

    instruction_decoder instruction_decoder_i (
        .instr   (fetched_instr),
        .flags   (flags),
        .decoded (decoded)
    );

    pipeline_sequencer pipeline_sequencer_i (
        .clk           (clk),
        .reset         (reset),
        .decoded       (decoded),
        .ctrl          (ctrl),
        .control_reset (control_reset),
        .fetch_strobe  (fetch_strobe)
    );

endmodule

// ==== verilog/pipeline_sequencer.sv ====
`timescale 1ns/1ps

module pipeline_sequencer
    import arm_isa_pkg::*;
    import control_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  decoded_ctrl_t  decoded,
    output datapath_ctrl_t ctrl,
    output logic           control_reset,
    output logic           fetch_strobe
);

    // controls held during reset
    localparam datapath_ctrl_t CTRL_IDLE = '{
        mem_write_en:   1'b0,
        read_a_sel:     REG_R0,
        read_b_sel:     REG_R0,
        read_b_en:      1'b1,
        write_sel:      REG_R0,
        reg_write_en:   1'b0,
        pc_write_en:    1'b0,
        cpsr_write_en:  1'b0,
        addr_sel:       ADDR_PC,
        update_address: 1'b0,
        shift_op:       SHIFT_LSL,
        shift_amount:   5'd0,
        alu_op:         ALU_MOV,
        immediate:      32'd0,
        imm_en:         1'b0,
        mem_data_en:    1'b0
    };

    seq_state_t state;
    seq_state_t state_next;
    logic       ex_is_store;  // execute-stage copy of is_store

    // --------------------------------------------------
    // state machine
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= RESET_1;
        end
        else
        begin
            state <= state_next;
        end
    end

    always_comb
    begin
        case (state)
            RESET_1:       state_next = RESET_2;
            RESET_2:       state_next = FETCH;
            FETCH:         state_next = DECODE;
            DECODE:        state_next = decoded.is_load_store ? EXECUTE_STORE : EXECUTE;
            EXECUTE_STORE: state_next = ex_is_store ? EXECUTE : EXECUTE_LOAD;
            EXECUTE_LOAD:  state_next = EXECUTE;
            EXECUTE:       state_next = FETCH;
            default:       state_next = RESET_1;
        endcase
    end

    // --------------------------------------------------
    // registered control outputs
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset || state == RESET_1)
        begin
            ctrl          <= CTRL_IDLE;
            control_reset <= 1'b1;   // hold the datapath in reset
            fetch_strobe  <= 1'b0;
            ex_is_store   <= 1'b0;
        end
        else
        begin
            fetch_strobe <= (state_next == FETCH);  // instruction word valid in FETCH

            case (state)
                RESET_2:
                begin
                    control_reset       <= 1'b0;
                    ctrl.pc_write_en    <= 1'b1;
                    ctrl.update_address <= 1'b1;
                    ctrl.addr_sel       <= ADDR_INC;
                end

                FETCH:
                begin
                    // end of the pc increment
                    ctrl.pc_write_en    <= 1'b0;
                    ctrl.update_address <= 1'b0;
                    ctrl.addr_sel       <= ADDR_PC;
                end

                DECODE:
                begin
                    ctrl.read_a_sel    <= decoded.read_a_sel;
                    ctrl.read_b_sel    <= decoded.read_b_sel;
                    ctrl.read_b_en     <= !decoded.imm_en;  // b bus has one driver
                    ctrl.write_sel     <= decoded.write_sel;
                    ctrl.reg_write_en  <= decoded.reg_write_en;
                    ctrl.cpsr_write_en <= decoded.cpsr_write_en;
                    ctrl.shift_op      <= decoded.shift_op;
                    ctrl.shift_amount  <= decoded.shift_amount;
                    ctrl.alu_op        <= decoded.alu_op;
                    ctrl.immediate     <= decoded.immediate;
                    ctrl.imm_en        <= decoded.imm_en;
                    ex_is_store        <= decoded.is_store;
                end

                EXECUTE_STORE:
                begin
                    // base plus offset stays on the alu
                    ctrl.mem_write_en   <= ex_is_store;
                    ctrl.addr_sel       <= ADDR_ALU;
                    ctrl.update_address <= 1'b1;
                end

                EXECUTE_LOAD:
                begin
                    ctrl.update_address <= 1'b0;           // hold the load address
                    ctrl.write_sel      <= ctrl.read_b_sel; // rd
                    ctrl.reg_write_en   <= 1'b1;
                    ctrl.read_b_en      <= 1'b0;
                    ctrl.imm_en         <= 1'b0;
                    ctrl.mem_data_en    <= 1'b1;
                    ctrl.alu_op         <= ALU_MOV;        // pass read data through
                    ctrl.shift_op       <= SHIFT_LSL;
                    ctrl.shift_amount   <= 5'd0;
                end

                EXECUTE:
                begin
                    ctrl.mem_write_en   <= 1'b0;
                    ctrl.reg_write_en   <= 1'b0;
                    ctrl.cpsr_write_en  <= 1'b0;
                    ctrl.mem_data_en    <= 1'b0;
                    ctrl.imm_en         <= 1'b0;
                    ctrl.read_b_en      <= 1'b1;
                    // pc increment marks the end of the instruction
                    ctrl.pc_write_en    <= 1'b1;
                    ctrl.update_address <= 1'b1;
                    ctrl.addr_sel       <= ADDR_INC;
                end

                default:
                begin
                    ctrl <= CTRL_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== verilog/instruction_decoder.sv ====
`timescale 1ns/1ps

module instruction_decoder
    import arm_isa_pkg::*;
    import control_pkg::*;
(
    input  word_t         instr,
    input  cpsr_flags_t   flags,
    output decoded_ctrl_t decoded
);

    // all enables low and no memory access
    localparam decoded_ctrl_t DECODED_NOP = '{
        is_load_store: 1'b0,
        is_store:      1'b0,
        read_a_sel:    REG_R0,
        read_b_sel:    REG_R0,
        write_sel:     REG_R0,
        shift_op:      SHIFT_LSL,
        shift_amount:  5'd0,
        alu_op:        ALU_MOV,
        immediate:     32'd0,
        imm_en:        1'b0,
        reg_write_en:  1'b0,
        cpsr_write_en: 1'b0
    };

    cond_t       cond;
    logic [2:0]  op_class;
    alu_op_t     opcode;
    logic        s_bit;
    reg_idx_t    rn;
    reg_idx_t    rd;
    reg_idx_t    rm;
    logic [3:0]  rotate;
    logic [7:0]  imm8;
    logic [63:0] imm_rot;
    shift_op_t   reg_shift_op;
    shift_amt_t  reg_shift_amt;
    logic        is_compare;
    logic        dp_valid;
    logic        executes;

    function automatic logic cond_passed(input cond_t cond_in, input cpsr_flags_t f);
        logic n;
        logic z;
        logic c;
        logic v;
        logic pass;
        n = f[FLAG_N];
        z = f[FLAG_Z];
        c = f[FLAG_C];
        v = f[FLAG_V];
        case (cond_in)
            COND_EQ: pass = z;
            COND_NE: pass = !z;
            COND_CS: pass = c;
            COND_CC: pass = !c;
            COND_MI: pass = n;
            COND_PL: pass = !n;
            COND_VS: pass = v;
            COND_VC: pass = !v;
            COND_HI: pass = c && !z;
            COND_LS: pass = !c || z;
            COND_GE: pass = (n == v);
            COND_LT: pass = (n != v);
            COND_GT: pass = !z && (n == v);
            COND_LE: pass = z || (n != v);
            COND_AL: pass = 1'b1;
            default: pass = 1'b0;  // 4'b1111 never runs here
        endcase
        return pass;
    endfunction

    // --------------------------------------------------
    // instruction fields
    // --------------------------------------------------
    assign cond     = cond_t'(instr[31:28]);
    assign op_class = instr[27:25];
    assign opcode   = alu_op_t'(instr[24:21]);
    assign s_bit    = instr[20];
    assign rn       = instr[19:16];
    assign rd       = instr[15:12];
    assign rm       = instr[3:0];
    assign rotate   = instr[11:8];
    assign imm8     = instr[7:0];

    assign executes = cond_passed(cond, flags);

    // rotate right by twice the rotate field
    assign imm_rot = {24'd0, imm8, 24'd0, imm8} >> {rotate, 1'b0};

    assign reg_shift_amt = instr[11:7];
    assign reg_shift_op  = (instr[6:5] == 2'b11 && reg_shift_amt == 5'd0)
                         ? SHIFT_RRX                          // ror #0 encodes rrx
                         : shift_op_t'({1'b0, instr[6:5]});

    assign is_compare = (instr[24:23] == 2'b10);  // tst teq cmp cmn
    // compare-type without s is the misc space (mrs/msr)
    assign dp_valid   = !(is_compare && !s_bit);

    // --------------------------------------------------
    // decode
    // --------------------------------------------------
    always_comb
    begin
        decoded = DECODED_NOP;
        if (executes)
        begin
            case (op_class)
                CLASS_DP_REG, CLASS_DP_IMM:
                begin
                    // bit 4 set means shift by register or multiply
                    if (dp_valid && (op_class == CLASS_DP_IMM || !instr[4]))
                    begin
                        decoded.read_a_sel    = rn;
                        decoded.write_sel     = rd;
                        decoded.alu_op        = opcode;
                        decoded.reg_write_en  = !is_compare && (rd != REG_PC);
                        decoded.cpsr_write_en = s_bit || is_compare;
                        if (op_class == CLASS_DP_IMM)
                        begin
                            decoded.immediate = imm_rot[31:0];
                            decoded.imm_en    = 1'b1;
                        end
                        else
                        begin
                            decoded.read_b_sel   = rm;
                            decoded.shift_op     = reg_shift_op;
                            decoded.shift_amount = reg_shift_amt;
                        end
                    end
                end

                CLASS_LS_IMM:
                begin
                    if (instr[24])  // pre-indexed
                    begin
                        decoded.is_load_store = 1'b1;
                        decoded.is_store      = !instr[20];
                        decoded.read_a_sel    = rn;  // base
                        decoded.read_b_sel    = rd;  // store data or load target
                        decoded.write_sel     = rd;
                        decoded.alu_op        = instr[23] ? ALU_ADD : ALU_SUB;
                        decoded.immediate     = {20'd0, instr[11:0]};
                        decoded.imm_en        = 1'b1;
                    end
                end

                default:
                begin
                    decoded = DECODED_NOP;
                end
            endcase
        end
    end

endmodule

// ==== verilog/control_pkg.sv ====
package control_pkg;
    import arm_isa_pkg::*;

    // --------------------------------------------------
    // sequencer states
    // --------------------------------------------------
    typedef enum logic [2:0] {
        RESET_1       = 3'b000,
        RESET_2       = 3'b001,
        FETCH         = 3'b010,
        DECODE        = 3'b011,
        EXECUTE       = 3'b100,
        EXECUTE_STORE = 3'b101,  // first memory cycle for ldr and str
        EXECUTE_LOAD  = 3'b110   // ldr only
    } seq_state_t;

    // source of the address register
    typedef enum logic [1:0] {
        ADDR_ALU = 2'b00,
        ADDR_PC  = 2'b01,
        ADDR_INC = 2'b10
    } addr_sel_t;

    // --------------------------------------------------
    // decoder output
    // --------------------------------------------------
    typedef struct packed {
        logic       is_load_store;
        logic       is_store;
        reg_idx_t   read_a_sel;
        reg_idx_t   read_b_sel;
        reg_idx_t   write_sel;
        shift_op_t  shift_op;
        shift_amt_t shift_amount;
        alu_op_t    alu_op;
        word_t      immediate;
        logic       imm_en;
        logic       reg_write_en;
        logic       cpsr_write_en;
    } decoded_ctrl_t;

    // --------------------------------------------------
    // registered datapath controls
    // --------------------------------------------------
    typedef struct packed {
        logic       mem_write_en;
        reg_idx_t   read_a_sel;
        reg_idx_t   read_b_sel;
        logic       read_b_en;       // register file drives the b bus
        reg_idx_t   write_sel;
        logic       reg_write_en;
        logic       pc_write_en;
        logic       cpsr_write_en;
        addr_sel_t  addr_sel;
        logic       update_address;
        shift_op_t  shift_op;
        shift_amt_t shift_amount;
        alu_op_t    alu_op;
        word_t      immediate;
        logic       imm_en;          // immediate drives the b bus
        logic       mem_data_en;     // memory read data drives the b bus
    } datapath_ctrl_t;

endpackage

// ==== verilog/arm_isa_pkg.sv ====
package arm_isa_pkg;

    // --------------------------------------------------
    // basic widths
    // --------------------------------------------------
    typedef logic [31:0] word_t;        // data or instruction word
    typedef logic [3:0]  reg_idx_t;     // register number r0..r15
    typedef logic [3:0]  cpsr_flags_t;  // {n, z, c, v}
    typedef logic [4:0]  shift_amt_t;   // immediate shift amount

    // bit positions inside cpsr_flags_t
    localparam int FLAG_N = 3;
    localparam int FLAG_Z = 2;
    localparam int FLAG_C = 1;
    localparam int FLAG_V = 0;

    localparam reg_idx_t REG_R0 = 4'd0;
    localparam reg_idx_t REG_PC = 4'd15;

    // instruction class in bits 27:25
    localparam logic [2:0] CLASS_DP_REG = 3'b000;  // data processing with shifted register
    localparam logic [2:0] CLASS_DP_IMM = 3'b001;  // data processing with rotated immediate
    localparam logic [2:0] CLASS_LS_IMM = 3'b010;  // load/store with 12-bit offset

    // --------------------------------------------------
    // data processing opcodes
    // --------------------------------------------------
    typedef enum logic [3:0] {
        ALU_AND = 4'b0000,
        ALU_EOR = 4'b0001,
        ALU_SUB = 4'b0010,
        ALU_RSB = 4'b0011,
        ALU_ADD = 4'b0100,
        ALU_ADC = 4'b0101,
        ALU_SBC = 4'b0110,
        ALU_RSC = 4'b0111,
        ALU_TST = 4'b1000,  // compare-type from here
        ALU_TEQ = 4'b1001,
        ALU_CMP = 4'b1010,
        ALU_CMN = 4'b1011,
        ALU_ORR = 4'b1100,
        ALU_MOV = 4'b1101,
        ALU_BIC = 4'b1110,
        ALU_MVN = 4'b1111
    } alu_op_t;

    typedef enum logic [2:0] {
        SHIFT_LSL = 3'b000,
        SHIFT_LSR = 3'b001,
        SHIFT_ASR = 3'b010,
        SHIFT_ROR = 3'b011,
        SHIFT_RRX = 3'b100   // rotate through carry by one
    } shift_op_t;

    // condition field in bits 31:28
    typedef enum logic [3:0] {
        COND_EQ = 4'b0000,
        COND_NE = 4'b0001,
        COND_CS = 4'b0010,
        COND_CC = 4'b0011,
        COND_MI = 4'b0100,
        COND_PL = 4'b0101,
        COND_VS = 4'b0110,
        COND_VC = 4'b0111,
        COND_HI = 4'b1000,
        COND_LS = 4'b1001,
        COND_GE = 4'b1010,
        COND_LT = 4'b1011,
        COND_GT = 4'b1100,
        COND_LE = 4'b1101,
        COND_AL = 4'b1110
    } cond_t;

    localparam word_t NOP_INSTRUCTION = 32'hE1A0_0000;  // mov r0, r0 (al)

endpackage
